/* verilog/pu_pkg.sv */
`default_nettype none

package pu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PIX_W     = 16;
    localparam int COL_LEN   = 5;
    localparam int WIN_COLS  = 5;
    localparam int HELD_COLS = WIN_COLS - 1;
    localparam int TAPS      = COL_LEN * WIN_COLS;
    localparam int ADDR_W    = 3;
    localparam int TAP_W     = 5;
    // 32-bit products, 25 of them summed.
    localparam int RES_W     = 2 * PIX_W + 5;
    localparam int LAST_ADDR = COL_LEN - 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        idle    = 2'b00,
        write_g = 2'b01,
        read_g  = 2'b10,
        write_r = 2'b11
    } pu_state_e;

    // Row 0 in the low bits.
    typedef struct packed {
        logic [COL_LEN-1:0][PIX_W-1:0] pix;
    } column_t;

    // Column 0 is the oldest.
    typedef struct packed {
        column_t [WIN_COLS-1:0] col;
    } window_t;

    typedef struct packed {
        logic own_wr;
        logic nbr_wr;
        logic use_nbr;
        logic shift;
        logic win_valid;
    } pu_ctrl_t;

endpackage

`default_nettype wire

/* verilog/column_buffer.sv */
`default_nettype none

module column_buffer (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        wr,
    input  logic [pu_pkg::ADDR_W-1:0]   addr,
    input  logic [pu_pkg::PIX_W-1:0]    pixel,
    output pu_pkg::column_t             column
);

    import pu_pkg::*;

    logic addr_ok;

    // Addresses past the last row are dropped.
    assign addr_ok = (addr <= ADDR_W'(LAST_ADDR));

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            column <= '0;
        end
        else if (wr && addr_ok)
        begin
            column.pix[addr] <= pixel;
        end
    end

endmodule

`default_nettype wire

/* verilog/window_regs.sv */
`default_nettype none

module window_regs (
    input  logic                clk,
    input  logic                nrst,
    input  logic                shift,
    input  pu_pkg::column_t     new_col,
    output pu_pkg::window_t     window
);

    import pu_pkg::*;

    // Entry 0 is the oldest column.
    column_t [HELD_COLS-1:0] held;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            held <= '0;
        end
        else if (shift)
        begin
            held[HELD_COLS-2:0] <= held[HELD_COLS-1:1];
            held[HELD_COLS-1]   <= new_col;
        end
    end

    // Held columns first, the incoming column last.
    always_comb
    begin
        window.col[HELD_COLS-1:0] = held;
        window.col[WIN_COLS-1]    = new_col;
    end

endmodule

`default_nettype wire

/* verilog/pu_control.sv */
`default_nettype none

module pu_control (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        start,
    input  logic                        round,
    input  logic                        pixel_wr,
    input  logic [pu_pkg::ADDR_W-1:0]   pixel_addr,
    input  logic                        neighbor_in_flag,
    output pu_pkg::pu_ctrl_t            ctrl,
    output pu_pkg::pu_state_e           state
);

    import pu_pkg::*;

    localparam int CNT_W = $clog2(HELD_COLS + 1);

    pu_state_e        state_next;
    logic             col_wr;
    logic             col_done;
    logic             use_nbr;
    logic [CNT_W-1:0] held_cnt;

    // Pixel strobes only count while the column is filling.
    assign col_wr   = pixel_wr && (state == write_g);
    assign col_done = col_wr && (pixel_addr == ADDR_W'(LAST_ADDR));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        state_next = state;
        case (state)
            idle:
            begin
                state_next = idle;
            end
            write_g:
            begin
                if (col_done)
                    state_next = read_g;
            end
            read_g:
            begin
                state_next = write_r;
            end
            write_r:
            begin
                state_next = write_g;
            end
            default:
            begin
                state_next = idle;
            end
        endcase
        // Restart from any state.
        if (start)
            state_next = write_g;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= idle;
        else
            state <= state_next;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fill count and round capture.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            held_cnt <= '0;
            use_nbr  <= 1'b0;
        end
        else
        begin
            if (start)
                held_cnt <= '0;
            else if (state == write_r && held_cnt != CNT_W'(HELD_COLS))
                held_cnt <= held_cnt + 1'b1;

            if (col_done)
                use_nbr <= round;
        end
    end

    always_comb
    begin
        ctrl.own_wr    = col_wr;
        ctrl.nbr_wr    = col_wr && neighbor_in_flag;
        ctrl.use_nbr   = use_nbr;
        ctrl.shift     = (state == write_r);
        // Full window once four columns sit behind the new one.
        ctrl.win_valid = (state == read_g) && (held_cnt == CNT_W'(HELD_COLS));
    end

endmodule

`default_nettype wire

/* verilog/conv_mac.sv */
`default_nettype none

module conv_mac (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        weight_wr,
    input  logic [pu_pkg::TAP_W-1:0]    weight_addr,
    input  logic [pu_pkg::PIX_W-1:0]    weight,
    input  logic                        win_valid,
    input  pu_pkg::window_t             window,
    output logic [pu_pkg::RES_W-1:0]    result,
    output logic                        result_valid
);

    import pu_pkg::*;

    logic [PIX_W-1:0] weight_mem [TAPS];
    logic [RES_W-1:0] dot;

    // Weight store, writable at any time.
    always_ff @(posedge clk)
    begin
        if (weight_wr && weight_addr < TAP_W'(TAPS))
            weight_mem[weight_addr] <= weight;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Dot product of window and weights.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin : dot_sum
        logic [2*PIX_W-1:0] prod;
        dot  = '0;
        prod = '0;
        for (int c = 0; c < WIN_COLS; c++)
        begin
            for (int r = 0; r < COL_LEN; r++)
            begin
                // Tap k is column * 5 + row.
                prod = window.col[c].pix[r] * weight_mem[c*COL_LEN + r];
                dot  = dot + RES_W'(prod);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (win_valid)
            result <= dot;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            result_valid <= 1'b0;
        else
            result_valid <= win_valid;
    end

endmodule

`default_nettype wire

/* verilog/pu_top.sv */
`default_nettype none

module pu_top (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        start,
    input  logic                        round,
    input  logic                        pixel_wr,
    input  logic [pu_pkg::ADDR_W-1:0]   pixel_addr,
    input  logic [pu_pkg::PIX_W-1:0]    pixel,
    input  logic                        neighbor_in_flag,
    input  logic [pu_pkg::PIX_W-1:0]    neighbor_pixel,
    input  logic                        weight_wr,
    input  logic [pu_pkg::TAP_W-1:0]    weight_addr,
    input  logic [pu_pkg::PIX_W-1:0]    weight,
    output logic                        col_ready,
    output pu_pkg::column_t             neighbor_out,
    output logic                        neighbor_out_flag,
    output logic [pu_pkg::RES_W-1:0]    result,
    output logic                        result_valid
);

    import pu_pkg::*;

    pu_ctrl_t  ctrl;
    pu_state_e state;
    column_t   own_col;
    column_t   nbr_col;
    column_t   sel_col;
    window_t   window;

    pu_control u_pu_control (
        .clk              (clk),
        .nrst             (nrst),
        .start            (start),
        .round            (round),
        .pixel_wr         (pixel_wr),
        .pixel_addr       (pixel_addr),
        .neighbor_in_flag (neighbor_in_flag),
        .ctrl             (ctrl),
        .state            (state)
    );

    column_buffer u_own_col (
        .clk    (clk),
        .nrst   (nrst),
        .wr     (ctrl.own_wr),
        .addr   (pixel_addr),
        .pixel  (pixel),
        .column (own_col)
    );

    column_buffer u_nbr_col (
        .clk    (clk),
        .nrst   (nrst),
        .wr     (ctrl.nbr_wr),
        .addr   (pixel_addr),
        .pixel  (neighbor_pixel),
        .column (nbr_col)
    );

    // Round 1 reuses the neighbour's column.
    assign sel_col = ctrl.use_nbr ? nbr_col : own_col;

    window_regs u_window_regs (
        .clk     (clk),
        .nrst    (nrst),
        .shift   (ctrl.shift),
        .new_col (sel_col),
        .window  (window)
    );

    conv_mac u_conv_mac (
        .clk          (clk),
        .nrst         (nrst),
        .weight_wr    (weight_wr),
        .weight_addr  (weight_addr),
        .weight       (weight),
        .win_valid    (ctrl.win_valid),
        .window       (window),
        .result       (result),
        .result_valid (result_valid)
    );

    assign col_ready         = (state == write_g);
    assign neighbor_out      = sel_col;
    assign neighbor_out_flag = (state == read_g);

endmodule

`default_nettype wire

/* test/pu_tb.sv */
`default_nettype none

module pu_tb;

    import pu_pkg::*;

    localparam int TOK_W = 8 * 16;

    logic              clk;
    logic              nrst;
    logic              start;
    logic              round;
    logic              pixel_wr;
    logic [ADDR_W-1:0] pixel_addr;
    logic [PIX_W-1:0]  pixel;
    logic              neighbor_in_flag;
    logic [PIX_W-1:0]  neighbor_pixel;
    logic              weight_wr;
    logic [TAP_W-1:0]  weight_addr;
    logic [PIX_W-1:0]  weight;
    logic              col_ready;
    column_t           neighbor_out;
    logic              neighbor_out_flag;
    logic [RES_W-1:0]  result;
    logic              result_valid;

    int errors = 0;
    int checks = 0;
    int n_cols = 0;
    int exp_results = 0;
    int valid_pulses = 0;
    int flag_pulses = 0;
    int vp = 0;
    int ep = 0;
    bit stim_loaded = 1'b0;

    // Parsed records, values in file order.
    logic [7:0]  kind_q[$];
    int          val_q[$];
    logic [63:0] exp_q[$];
    bit          has_q[$];

    pu_top u_pu_top (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    // Pulse counts, sampled mid-cycle.
    always @(negedge clk)
    begin
        if (result_valid)
            valid_pulses++;
        if (neighbor_out_flag)
            flag_pulses++;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
        checks++;
        assert (got == expected)
        else
        begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, got);
            errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus file.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic read_stim();
        int               fd;
        int               code;
        int               v;
        int               short_reads;
        logic [TOK_W-1:0] tok;
        logic [8*128-1:0] rest;
        logic [63:0]      ev;
        short_reads = 0;
        fd = $fopen("test/pu_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file test/pu_stim.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1)
        begin
            if (tok == TOK_W'("#"))
            begin
                void'($fgets(rest, fd));
            end
            else if (tok == TOK_W'("W") || tok == TOK_W'("S"))
            begin
                kind_q.push_back(tok[7:0]);
                for (int k = 0; k < TAPS && tok == TOK_W'("W"); k++)
                begin
                    code = $fscanf(fd, "%d", v);
                    if (code != 1)
                        short_reads++;
                    val_q.push_back(v);
                end
            end
            else if (tok == TOK_W'("C"))
            begin
                kind_q.push_back(tok[7:0]);
                for (int k = 0; k < 2 * COL_LEN + 2; k++)
                begin
                    code = $fscanf(fd, "%d", v);
                    if (code != 1)
                        short_reads++;
                    val_q.push_back(v);
                end
                code = $fscanf(fd, "%s", tok);
                if (code != 1)
                    short_reads++;
                ev = '0;
                if (tok != TOK_W'("none"))
                begin
                    code = $sscanf(tok, "%d", ev);
                    if (code != 1)
                        short_reads++;
                    exp_results++;
                end
                has_q.push_back(tok != TOK_W'("none"));
                exp_q.push_back(ev);
                n_cols++;
            end
            else
            begin
                $display("Unknown record in the stimulus file");
                errors++;
            end
        end
        if (short_reads != 0)
        begin
            $display("The stimulus file has %0d missing or unreadable values", short_reads);
            errors++;
        end
        $fclose(fd);
    endtask

    task automatic load_weights();
        for (int k = 0; k < TAPS; k++)
        begin
            weight_wr   = 1'b1;
            weight_addr = TAP_W'(k);
            weight      = PIX_W'(val_q[vp]);
            vp++;
            idle_cycles(1);
        end
        weight_wr = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        idle_cycles(1);
        start = 1'b0;
    endtask

    task automatic check_before_start();
        for (int c = 0; c < 6; c++)
        begin
            // Last-row strobe while idle.
            pixel_wr   = (c == 2);
            pixel_addr = ADDR_W'(LAST_ADDR);
            idle_cycles(1);
            pixel_wr = 1'b0;
            check_val("col_ready", 64'(col_ready), 64'd0);
            check_val("neighbor_out_flag", 64'(neighbor_out_flag), 64'd0);
            check_val("result_valid", 64'(result_valid), 64'd0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One column and its responses.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_column();
        int          rnd;
        int          flag;
        int          own_pix[COL_LEN];
        int          nbr_pix[COL_LEN];
        bit          has_exp;
        logic [63:0] exp_val;
        rnd  = val_q[vp];
        flag = val_q[vp+11];
        for (int r = 0; r < COL_LEN; r++)
        begin
            own_pix[r] = val_q[vp+1+r];
            nbr_pix[r] = val_q[vp+6+r];
        end
        vp += 12;
        has_exp = has_q[ep];
        exp_val = exp_q[ep];
        ep++;
        while (col_ready !== 1'b1)
            idle_cycles(1);
        round            = rnd[0];
        neighbor_in_flag = flag[0];
        for (int r = 0; r < COL_LEN; r++)
        begin
            idle_cycles(int'($urandom_range(3, 0)));
            pixel_wr       = 1'b1;
            pixel_addr     = ADDR_W'(r);
            pixel          = PIX_W'(own_pix[r]);
            neighbor_pixel = PIX_W'(nbr_pix[r]);
            idle_cycles(1);
            pixel_wr = 1'b0;
        end
        check_val("col_ready", 64'(col_ready), 64'd0);
        check_val("result_valid", 64'(result_valid), 64'd0);
        check_val("neighbor_out_flag", 64'(neighbor_out_flag), 64'd1);
        for (int r = 0; r < COL_LEN; r++)
            check_val($sformatf("neighbor_out.pix[%0d]", r), 64'(neighbor_out.pix[r]),
                      64'(rnd != 0 ? nbr_pix[r] : own_pix[r]));
        // Would flip the captured round if not ignored.
        pixel_wr       = 1'b1;
        pixel_addr     = ADDR_W'(LAST_ADDR);
        round          = ~rnd[0];
        pixel          = PIX_W'($urandom);
        neighbor_pixel = PIX_W'($urandom);
        idle_cycles(1);
        pixel_wr = 1'b0;
        check_val("result_valid", 64'(result_valid), 64'(has_exp));
        if (has_exp)
            check_val("result", 64'(result), exp_val);
        check_val("neighbor_out_flag", 64'(neighbor_out_flag), 64'd0);
        idle_cycles(1);
        check_val("result_valid", 64'(result_valid), 64'd0);
        check_val("col_ready", 64'(col_ready), 64'd1);
    endtask

    initial
    begin
        void'($urandom(15408));
        nrst             = 1'b0;
        start            = 1'b0;
        round            = 1'b0;
        pixel_wr         = 1'b0;
        pixel_addr       = '0;
        pixel            = '0;
        neighbor_in_flag = 1'b0;
        neighbor_pixel   = '0;
        weight_wr        = 1'b0;
        weight_addr      = '0;
        weight           = '0;
        read_stim();
        stim_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;
        check_before_start();
        foreach (kind_q[i])
        begin
            case (kind_q[i])
                "W": load_weights();
                "S": pulse_start();
                default: run_column();
            endcase
        end
        idle_cycles(4);
        check_val("result_valid pulses", 64'(valid_pulses), 64'(exp_results));
        check_val("neighbor_out_flag pulses", 64'(flag_pulses), 64'(n_cols));
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // Watchdog.
    initial
    begin
        wait (stim_loaded);
        repeat (n_cols * 40 + 200) @(posedge clk);
        $display("timeout waiting for result");
        $display("checks %0d, errors %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/pu_stim.txt */
# W is followed by 25 weights, tap k = column*5 + row, oldest column first.
# S pulses start.
# C round own0..own4 nbr0..nbr4 flag expected (a number, or none).

# Column weights 1 to 5.
W 1 1 1 1 1 2 2 2 2 2 3 3 3 3 3 4 4 4 4 4 5 5 5 5 5
S
C 0 1 1 1 1 1 9 9 9 9 9 0 none
C 0 2 2 2 2 2 0 0 0 0 0 0 none
C 1 7 7 7 7 7 3 3 3 3 3 1 none
C 0 4 4 4 4 4 50 50 50 50 50 1 none
C 0 1 2 3 4 5 0 0 0 0 0 0 225
C 1 100 100 100 100 100 10 20 30 40 50 1 910
C 0 1000 0 0 0 0 5 5 5 5 5 1 5700
C 0 65535 65535 65535 65535 65535 0 0 0 0 0 0 1642875

# Row weights 1 to 5, reloaded mid-stream, then a restart.
W 1 2 3 4 5 1 2 3 4 5 1 2 3 4 5 1 2 3 4 5 1 2 3 4 5
S
C 1 0 0 0 0 0 1 0 0 0 0 1 none
C 0 0 1 0 0 0 9 9 9 9 9 1 none
C 0 0 0 1 0 0 0 0 0 0 0 0 none
C 0 0 0 0 1 0 0 0 0 0 0 0 none
C 0 0 0 0 0 1 0 0 0 0 0 0 15
C 1 0 0 0 0 0 2 2 2 2 2 1 44
C 0 65535 65535 65535 65535 65535 0 0 0 0 0 0 983067

# Full scale, needs all 37 result bits.
W
65535 65535 65535 65535 65535
65535 65535 65535 65535 65535
65535 65535 65535 65535 65535
65535 65535 65535 65535 65535
65535 65535 65535 65535 65535
S
C 0 65535 65535 65535 65535 65535 0 0 0 0 0 0 none
C 1 0 0 0 0 0 65535 65535 65535 65535 65535 1 none
C 0 65535 65535 65535 65535 65535 1 2 3 4 5 1 none
C 1 7 7 7 7 7 65535 65535 65535 65535 65535 1 none
C 0 65535 65535 65535 65535 65535 0 0 0 0 0 0 107370905625

/* build.f */
verilog/pu_pkg.sv
verilog/column_buffer.sv
verilog/window_regs.sv
verilog/pu_control.sv
verilog/conv_mac.sv
verilog/pu_top.sv
test/pu_tb.sv

/* Makefile */
# Verilator build and run of the processing unit testbench.

VERILATOR ?= verilator
TOP       ?= pu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

# The run passes only if the log holds the pass message.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
